// ==== Makefile ====
# Verilator simulation of the decode stage

TOP = tb_decode_stage
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f project.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Done: no errors$$" $(LOG) && echo "PASS" || \
		(echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== control_logic.sv ====
// Opcode decoder
`timescale 1ns/1ps

module control_logic
    import cpu_pkg::*;
(
    input  opcode_e    opcode,
    output ctrl_t      ctrl,
    output logic       use_rs,       // rs read, checked for hazards
    output logic       use_rt,       // Selected rt read, checked for hazards
    output logic       rt_from_mem,  // Port 2 from mem-view register
    output logic [1:0] base_sel      // Port 1 source
);

    always_comb begin
        // Defaults give a NOP
        ctrl        = '0;
        use_rs      = 1'b0;
        use_rt      = 1'b0;
        rt_from_mem = 1'b0;
        base_sel    = BASE_RS;

        case (opcode)
            OP_ADD: begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.reg_write = 1'b1;
                use_rs         = 1'b1;
                use_rt         = 1'b1;
            end
            OP_SUB: begin
                ctrl.alu_op    = ALU_SUB;
                ctrl.reg_write = 1'b1;
                use_rs         = 1'b1;
                use_rt         = 1'b1;
            end
            OP_AND: begin
                ctrl.alu_op    = ALU_AND;
                ctrl.reg_write = 1'b1;
                use_rs         = 1'b1;
                use_rt         = 1'b1;
            end
            OP_OR: begin
                ctrl.alu_op    = ALU_OR;
                ctrl.reg_write = 1'b1;
                use_rs         = 1'b1;
                use_rt         = 1'b1;
            end
            OP_ADDI: begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.alu_src   = 1'b1;  // imm4 replaces rt
                ctrl.reg_write = 1'b1;
                use_rs         = 1'b1;
            end
            OP_LW: begin
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = ALU_ADD;  // DS + imm8
                ctrl.reg_write  = 1'b1;
                use_rs          = 1'b1;
                base_sel        = BASE_DS;
            end
            OP_SW: begin
                ctrl.reg_to_mem = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = ALU_ADD;
                use_rs          = 1'b1;
                use_rt          = 1'b1;  // Store data register
                rt_from_mem     = 1'b1;
                base_sel        = BASE_DS;
            end
            OP_BR: begin
                ctrl.branch = 1'b1;
            end
            OP_CALL: begin
                ctrl.call = 1'b1;
                base_sel  = BASE_SP;  // SP never hazard-checked
            end
            OP_RET: begin
                ctrl.ret = 1'b1;
                base_sel = BASE_SP;
            end
            default: begin
                // Opcodes 10..15, keep NOP defaults
            end
        endcase
    end

    // PC updater takes at most one redirect kind per instruction
    always_comb begin
        a_one_redirect: assert ($onehot0({ctrl.branch, ctrl.call, ctrl.ret}))
            else $error("%0t control_logic: branch/call/ret overlap", $time);
    end

endmodule

// ==== cpu_defines.svh ====
// CPU core parameters
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath width, shared by register data and PC
`define CPU_XLEN 16

// Architectural register count
`define CPU_NREGS 16

// Dedicated registers
`define CPU_SP_REG 15  // Stack pointer, base for CALL and RET
`define CPU_DS_REG 14  // Data segment, base for LW and SW

// Stack starts at top of memory
`define CPU_SP_RESET {`CPU_XLEN{1'b1}}

`endif

// ==== cpu_pkg.sv ====
// CPU decode types
`include "cpu_defines.svh"

package cpu_pkg;

    localparam int REG_AW = $clog2(`CPU_NREGS);  // Register index width

    // Base register select codes for read port 1
    localparam logic [1:0] BASE_RS = 2'd0;  // Instruction rs
    localparam logic [1:0] BASE_DS = 2'd1;  // Data segment
    localparam logic [1:0] BASE_SP = 2'd2;  // Stack pointer

    // Opcodes 10 to 15 unassigned, decode as NOP
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_ADDI = 4'd4,
        OP_LW   = 4'd5,
        OP_SW   = 4'd6,
        OP_BR   = 4'd7,
        OP_CALL = 4'd8,
        OP_RET  = 4'd9
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4
    } alu_op_e;

    // Register-register and 4-bit immediate format
    typedef struct packed {
        opcode_e             opcode;
        logic [REG_AW-1:0]   rd;
        logic [REG_AW-1:0]   rs;
        logic [REG_AW-1:0]   rt;  // Also imm4 for ADDI
    } arith_fmt_t;

    // Load/store format
    typedef struct packed {
        opcode_e             opcode;
        logic [REG_AW-1:0]   rm;   // LW dest, SW data source
        logic [7:0]          imm;
    } mem_fmt_t;

    // Call format
    typedef struct packed {
        opcode_e             opcode;
        logic [11:0]         target;
    } call_fmt_t;

    // One instruction word, three views
    typedef union packed {
        arith_fmt_t arith;
        mem_fmt_t   mem;
        call_fmt_t  call;
    } instr_t;

    typedef struct packed {
        logic    mem_to_reg;  // LW
        logic    reg_to_mem;  // SW
        logic    alu_src;     // Immediate as ALU operand B
        alu_op_e alu_op;
        logic    branch;
        logic    call;
        logic    ret;
        logic    reg_write;
    } ctrl_t;

    typedef struct packed {
        logic                 valid;
        ctrl_t                ctrl;
        logic [`CPU_XLEN-1:0] read_data_1;
        logic [`CPU_XLEN-1:0] read_data_2;
        logic [`CPU_XLEN-1:0] sign_ext;
        logic [REG_AW-1:0]    rd;
        logic [2:0]           branch_cond;
        logic [11:0]          call_target;
        logic [`CPU_XLEN-1:0] pc;
    } id_ex_t;

    // In-flight destination reported by a later stage
    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rnum;
    } dst_tag_t;

endpackage

// ==== decode_stage.sv ====
// Instruction decode stage
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decode_stage
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,          // Sync, active high

    // From fetch
    input  instr_t               instr,
    input  logic [`CPU_XLEN-1:0] pc,
    input  logic                 instr_valid,

    // From write-back
    input  logic                 wb_en,
    input  logic [REG_AW-1:0]    wb_reg,
    input  logic [`CPU_XLEN-1:0] wb_data,

    // In-flight destinations
    input  dst_tag_t             idex_dst,
    input  dst_tag_t             exmem_dst,
    input  dst_tag_t             memwb_dst,

    input  logic                 ex_hold,      // Back-pressure from EX

    output id_ex_t               id_ex,
    output logic                 stall         // Fetch holds its word
);

    // Register file port signals
    logic                 rf_we;
    logic [REG_AW-1:0]    rf_waddr;
    logic [`CPU_XLEN-1:0] rf_wdata;
    logic [REG_AW-1:0]    rf_raddr_1;
    logic [REG_AW-1:0]    rf_raddr_2;
    logic [`CPU_XLEN-1:0] rf_rdata_1;
    logic [`CPU_XLEN-1:0] rf_rdata_2;

    // Decoder outputs
    ctrl_t                dec_ctrl;
    logic                 use_rs;
    logic                 use_rt;
    logic                 rt_from_mem;
    logic [1:0]           base_sel;

    logic [REG_AW-1:0]    rt_sel;      // rt or SW data register
    logic                 raw_hazard;  // Ungated
    logic                 hazard;
    logic                 accept;      // Instruction moves into ID/EX
    logic [`CPU_XLEN-1:0] sign_ext;
    id_ex_t               id_ex_next;

    // Write port mux, reset turns it into the SP initializer
    always_comb begin
        if (rst) begin
            rf_we    = 1'b1;
            rf_waddr = REG_AW'(`CPU_SP_REG);
            rf_wdata = `CPU_SP_RESET;
        end else begin
            rf_we    = wb_en;
            rf_waddr = wb_reg;
            rf_wdata = wb_data;
        end
    end

    control_logic u_ctrl (
        .opcode      (instr.arith.opcode),
        .ctrl        (dec_ctrl),
        .use_rs      (use_rs),
        .use_rt      (use_rt),
        .rt_from_mem (rt_from_mem),
        .base_sel    (base_sel)
    );

    // SW reads its store data through port 2
    assign rt_sel = rt_from_mem ? instr.mem.rm : instr.arith.rt;

    // Port 1 base select
    always_comb begin
        case (base_sel)
            BASE_DS: rf_raddr_1 = REG_AW'(`CPU_DS_REG);  // LW/SW
            BASE_SP: rf_raddr_1 = REG_AW'(`CPU_SP_REG);  // CALL/RET
            default: rf_raddr_1 = instr.arith.rs;
        endcase
    end

    assign rf_raddr_2 = rt_sel;

    reg_file u_rf (
        .clk     (clk),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .raddr_1 (rf_raddr_1),
        .raddr_2 (rf_raddr_2),
        .rdata_1 (rf_rdata_1),
        .rdata_2 (rf_rdata_2)
    );

    hazard_unit u_hdu (
        .rs        (instr.arith.rs),
        .rt        (rt_sel),
        .use_rs    (use_rs),
        .use_rt    (use_rt),
        .idex_dst  (idex_dst),
        .exmem_dst (exmem_dst),
        .memwb_dst (memwb_dst),
        .hazard    (raw_hazard)
    );

    // Only a real instruction can hazard
    assign hazard = instr_valid & raw_hazard;

    // Stall held low through reset
    assign stall  = ~rst & (hazard | ex_hold);
    assign accept = instr_valid & ~stall;

    // imm4 for ADDI, imm8 otherwise
    always_comb begin
        if (instr.arith.opcode == OP_ADDI) begin
            sign_ext = {{(`CPU_XLEN-4){instr.arith.rt[3]}}, instr.arith.rt};
        end else begin
            sign_ext = {{(`CPU_XLEN-8){instr.mem.imm[7]}}, instr.mem.imm};
        end
    end

    // Next ID/EX word plus bubble mux
    always_comb begin
        id_ex_next.valid       = 1'b1;
        id_ex_next.ctrl        = dec_ctrl;
        id_ex_next.read_data_1 = rf_rdata_1;
        id_ex_next.read_data_2 = rf_rdata_2;
        id_ex_next.sign_ext    = sign_ext;
        id_ex_next.rd          = instr.arith.rd;  // Same bits as LW mem-view rm
        id_ex_next.branch_cond = instr.arith.rd[2:0];  // Bits [10:8]
        id_ex_next.call_target = instr.call.target;
        id_ex_next.pc          = pc;
        if (!accept) begin
            id_ex_next.valid = 1'b0;  // Bubble
            id_ex_next.ctrl  = '0;
        end
    end

    // ID/EX pipeline register
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex <= '0;
        end else if (!ex_hold) begin  // Hold freezes everything
            id_ex <= id_ex_next;
        end
    end

    // Back-pressure must always reach fetch
    a_hold_stalls: assert property (
        @(posedge clk) disable iff (rst) ex_hold |-> stall
    ) else $error("%0t decode_stage: ex_hold without stall", $time);

    // Held ID/EX word survives the cycle
    a_hold_keeps: assert property (
        @(posedge clk) disable iff (rst) (ex_hold && !rst) |=> $stable(id_ex)
    ) else $error("%0t decode_stage: id_ex changed under ex_hold", $time);

endmodule

// ==== hazard_unit.sv ====
// Load-use and RAW hazard detect
`timescale 1ns/1ps

module hazard_unit
    import cpu_pkg::*;
(
    input  logic [REG_AW-1:0] rs,
    input  logic [REG_AW-1:0] rt,         // Already selected for SW
    input  logic              use_rs,
    input  logic              use_rt,
    input  dst_tag_t          idex_dst,   // Dest in EX
    input  dst_tag_t          exmem_dst,  // Dest in MEM
    input  dst_tag_t          memwb_dst,  // Dest in WB
    output logic              hazard      // Not gated by instr_valid
);

    logic rs_hit;
    logic rt_hit;

    // One valid tag against one source
    function automatic logic tag_hit(dst_tag_t tag, logic [REG_AW-1:0] src);
        return tag.valid && (tag.rnum == src);
    endfunction

    // Any stage still owning rs
    assign rs_hit = tag_hit(idex_dst, rs)
                  | tag_hit(exmem_dst, rs)
                  | tag_hit(memwb_dst, rs);

    // Any stage still owning rt
    assign rt_hit = tag_hit(idex_dst, rt)
                  | tag_hit(exmem_dst, rt)
                  | tag_hit(memwb_dst, rt);

    // Only sources the opcode actually reads count
    assign hazard = (use_rs & rs_hit) | (use_rt & rt_hit);

endmodule

// ==== project.f ====
+incdir+.
cpu_pkg.sv
reg_file.sv
control_logic.sv
hazard_unit.sv
decode_stage.sv
tb_decode_stage.sv

// ==== reg_file.sv ====
// Register file
`timescale 1ns/1ps
`include "cpu_defines.svh"

module reg_file
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 we,       // Write enable
    input  logic [REG_AW-1:0]    waddr,
    input  logic [`CPU_XLEN-1:0] wdata,
    input  logic [REG_AW-1:0]    raddr_1,  // Base / rs port
    input  logic [REG_AW-1:0]    raddr_2,  // rt port
    output logic [`CPU_XLEN-1:0] rdata_1,
    output logic [`CPU_XLEN-1:0] rdata_2
);

    // Register storage
    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    // Write on rising edge
    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational reads
    // No write bypass, same-cycle read sees old value
    assign rdata_1 = regs[raddr_1];
    assign rdata_2 = regs[raddr_2];

    // A write must never store unknown data into the file
    a_wdata_known: assert property (
        @(posedge clk) we |-> !$isunknown({waddr, wdata})
    ) else $error("%0t reg_file: write with unknown addr/data", $time);

endmodule

// ==== tb_decode_stage.sv ====
// Decode stage testbench
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_decode_stage
    import cpu_pkg::*;
();

    localparam int ACCEPT_LIMIT = 20;  // Edges before an instruction counts as lost

    logic                 clk = 1'b0;
    logic                 rst;
    instr_t               instr;
    logic [`CPU_XLEN-1:0] pc;
    logic                 instr_valid;
    logic                 wb_en;
    logic [REG_AW-1:0]    wb_reg;
    logic [`CPU_XLEN-1:0] wb_data;
    dst_tag_t             idex_dst;
    dst_tag_t             exmem_dst;
    dst_tag_t             memwb_dst;
    logic                 ex_hold;
    id_ex_t               id_ex;
    logic                 stall;

    logic [`CPU_XLEN-1:0] model_regs [`CPU_NREGS];  // Register file as seen by write-back
    logic [15:0]          iw;          // Raw instruction bits
    logic [3:0]           exp_op;
    logic [3:0]           rt_chk;      // Second source checked for hazards
    logic                 use_rs_exp;
    logic                 use_rt_exp;
    logic                 hz_exp;      // Hazard per the stall rules
    logic                 acc_exp;     // Instruction taken on this edge
    id_ex_t               exp_next;
    id_ex_t               exp_q;       // Expected ID/EX one edge later
    int                   mismatches = 0;
    int                   timeouts = 0;

    always #4 clk = ~clk;

    decode_stage DUT (.*);

    // Decode table, field by field
    function automatic ctrl_t ctrl_for(logic [3:0] op);
        ctrl_t c;
        c = '0;
        case (op)
            OP_ADD:  c.alu_op = ALU_ADD;
            OP_SUB:  c.alu_op = ALU_SUB;
            OP_AND:  c.alu_op = ALU_AND;
            OP_OR:   c.alu_op = ALU_OR;
            OP_ADDI, OP_LW, OP_SW: c.alu_op = ALU_ADD;
            OP_BR:   c.branch = 1'b1;
            OP_CALL: c.call   = 1'b1;
            OP_RET:  c.ret    = 1'b1;
            default: c = '0;  // 10..15 are NOP
        endcase
        c.reg_write  = (op <= 4'd5);  // ALU ops, ADDI, LW
        c.alu_src    = (op >= 4'd4) && (op <= 4'd6);
        c.mem_to_reg = (op == OP_LW);
        c.reg_to_mem = (op == OP_SW);
        return c;
    endfunction

    // Register still owned by a later stage
    function automatic logic in_flight(logic [3:0] r, dst_tag_t a, dst_tag_t b, dst_tag_t c);
        return (a.valid && a.rnum == r)
            || (b.valid && b.rnum == r)
            || (c.valid && c.rnum == r);
    endfunction

    // Write-back model, SP forced during reset
    always @(posedge clk) begin
        if (rst) begin
            model_regs[`CPU_SP_REG] <= `CPU_SP_RESET;
        end else if (wb_en) begin
            model_regs[wb_reg] <= wb_data;
        end
    end

    assign iw         = instr;
    assign exp_op     = iw[15:12];
    assign use_rs_exp = (exp_op <= 4'd6);
    assign use_rt_exp = (exp_op <= 4'd3) || (exp_op == OP_SW);
    assign rt_chk     = (exp_op == OP_SW) ? iw[11:8] : iw[3:0];  // SW data register
    assign hz_exp     = instr_valid
                      && ((use_rs_exp && in_flight(iw[7:4], idex_dst, exmem_dst, memwb_dst))
                      || (use_rt_exp && in_flight(rt_chk, idex_dst, exmem_dst, memwb_dst)));
    assign acc_exp    = instr_valid && !hz_exp && !ex_hold;

    always_comb begin
        exp_next       = '0;
        exp_next.valid = 1'b1;
        exp_next.ctrl  = ctrl_for(exp_op);
        case (exp_op)
            OP_LW, OP_SW:    exp_next.read_data_1 = model_regs[`CPU_DS_REG];
            OP_CALL, OP_RET: exp_next.read_data_1 = model_regs[`CPU_SP_REG];
            default:         exp_next.read_data_1 = model_regs[iw[7:4]];
        endcase
        exp_next.read_data_2 = model_regs[rt_chk];
        if (exp_op == OP_ADDI) begin
            exp_next.sign_ext = {{12{iw[3]}}, iw[3:0]};
        end else begin
            exp_next.sign_ext = {{8{iw[7]}}, iw[7:0]};
        end
        exp_next.rd          = iw[11:8];
        exp_next.branch_cond = iw[10:8];
        exp_next.call_target = iw[11:0];
        exp_next.pc          = pc;
    end

    always @(posedge clk) exp_q <= exp_next;

    task automatic report_mismatch(input string msg);
        mismatches++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    a_word: assert property (@(posedge clk) disable iff (rst) acc_exp |=> id_ex == exp_q)
        else report_mismatch("id_ex differs from the decoded instruction");
    a_bubble: assert property (@(posedge clk) disable iff (rst)
        (!acc_exp && !ex_hold) |=> (!id_ex.valid && id_ex.ctrl == '0))
        else report_mismatch("id_ex is not a bubble");
    a_stall: assert property (@(posedge clk) disable iff (rst) stall == (ex_hold || hz_exp))
        else report_mismatch("stall disagrees with hazard and hold");
    a_held: assert property (@(posedge clk) disable iff (rst) ex_hold |=> $stable(id_ex))
        else report_mismatch("id_ex changed under ex_hold");
    a_reset: assert property (@(posedge clk)
        rst |=> (!stall && !id_ex.valid && id_ex.ctrl == '0))
        else report_mismatch("stage not quiet in reset");

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic present(input logic [3:0] op, input logic [11:0] low);
        instr       = {op, low};
        pc          = 16'($urandom);
        instr_valid = 1'b1;
    endtask

    // Ends 1 ns after the accepting edge
    task automatic wait_accept();
        int n;
        n = 0;
        @(posedge clk);
        while (stall && n < ACCEPT_LIMIT) begin
            n++;
            @(posedge clk);
        end
        if (stall) begin
            timeouts++;
            $display("timeout at %0t: instruction %h never accepted", $time, iw);
        end
        #1;
    endtask

    task automatic issue(input logic [3:0] op, input logic [11:0] low);
        present(op, low);
        wait_accept();
    endtask

    task automatic set_tag(input int s, input logic v, input logic [3:0] r);
        dst_tag_t t;
        t.valid = v;
        t.rnum  = r;
        case (s)
            0:       idex_dst  = t;
            1:       exmem_dst = t;
            default: memwb_dst = t;
        endcase
    endtask

    task automatic clear_tags();
        idex_dst  = '0;
        exmem_dst = '0;
        memwb_dst = '0;
    endtask

    initial begin
        void'($urandom(4869));
        rst         = 1'b1;
        instr       = '0;    // ADD r0, r0, r0
        pc          = '0;
        instr_valid = 1'b1;  // Live word under reset
        wb_en       = 1'b0;
        wb_reg      = '0;
        wb_data     = '0;
        ex_hold     = 1'b1;
        clear_tags();
        set_tag(0, 1'b1, 4'd0);  // rs hazard while in reset
        repeat (2) @(posedge clk);
        #1;
        ex_hold = 1'b0;  // Acceptable word, reset keeps ID/EX empty
        clear_tags();
        repeat (2) @(posedge clk);
        #1;
        rst         = 1'b0;
        instr_valid = 1'b0;

        // Known data in r0..r14, r15 keeps its reset value
        for (int r = 0; r < 15; r++) begin
            wb_en   = 1'b1;
            wb_reg  = 4'(r);
            wb_data = 16'($urandom);
            step();
        end
        wb_en = 1'b0;
        issue(OP_CALL, 12'($urandom));
        issue(OP_RET, 12'($urandom));

        // Register ops with write-back running alongside
        for (int i = 0; i < 24; i++) begin
            wb_en   = 1'($urandom);
            wb_reg  = 4'($urandom_range(14, 0));
            wb_data = 16'($urandom);
            issue(4'($urandom_range(3, 0)), 12'($urandom));
        end
        wb_en   = 1'b1;
        wb_reg  = 4'd3;
        wb_data = 16'h5a5a;
        issue(OP_ADD, 12'h133);  // Same-cycle read sees old r3
        wb_en = 1'b0;
        issue(OP_SUB, 12'h233);

        // Immediates and memory ops
        issue(OP_ADDI, 12'h218);
        issue(OP_ADDI, 12'h347);
        issue(OP_LW, 12'h580);
        issue(OP_SW, 12'h67f);
        for (int i = 0; i < 12; i++) begin
            issue(4'($urandom_range(6, 4)), 12'($urandom));
        end
        for (int op = 0; op < 16; op++) begin
            issue(4'(op), 12'($urandom));
        end
        instr_valid = 1'b0;
        step();

        // Hazards from each later stage
        for (int s = 0; s < 3; s++) begin
            present(OP_ADD, 12'h162);
            set_tag(s, 1'b1, 4'd6);
            repeat (2) step();
            clear_tags();
            wait_accept();
            present(OP_OR, 12'h1a9);
            set_tag(s, 1'b1, 4'd9);
            repeat (2) step();
            clear_tags();
            wait_accept();
        end
        present(OP_SW, 12'hb40);
        set_tag(1, 1'b1, 4'hb);
        repeat (2) step();
        clear_tags();
        wait_accept();
        present(OP_LW, 12'h2c0);
        set_tag(2, 1'b1, 4'hc);
        step();
        clear_tags();
        wait_accept();

        // Tags that must not stall
        set_tag(0, 1'b0, 4'd6);
        issue(OP_ADD, 12'h162);
        set_tag(2, 1'b1, 4'd5);
        issue(OP_ADDI, 12'h315);  // rt field is an immediate
        set_tag(1, 1'b1, 4'hf);
        issue(OP_CALL, 12'hfff);
        clear_tags();

        // Back-pressure from execute
        issue(OP_AND, 12'h421);
        present(OP_SUB, 12'h534);
        ex_hold = 1'b1;
        repeat (3) step();
        ex_hold = 1'b0;
        wait_accept();
        instr_valid = 1'b0;
        ex_hold     = 1'b1;
        repeat (2) step();
        ex_hold = 1'b0;
        repeat (3) step();

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
